// File: project.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/instr_decode.sv
rtl/control_fsm.sv
rtl/alu.sv
rtl/register_file.sv
rtl/core.sv
tests/tb_memory.sv
tests/tb_core.sv

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu (
    input  core_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              zero
);
    import core_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end

    // Branch compares look at this after a subtract
    assign zero = (result == 32'd0);

endmodule

// File: rtl/control_fsm.sv
`timescale 1ns/1ns

module control_fsm (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::opcode_e opcode,
    input  logic [2:0]       funct3,
    output core_pkg::ctrl_t  ctrl
);
    import isa_pkg::*;
    import core_pkg::*;

    fsm_state_e state;
    fsm_state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ST_FETCH: begin
                next_state = ST_DECODE;
            end
            ST_DECODE: begin
                case (opcode)
                    OPC_BRANCH: next_state = ST_BRANCH_DONE;
                    OPC_OP, OPC_OP_IMM, OPC_LOAD,
                    OPC_STORE, OPC_LUI, OPC_JAL: next_state = ST_EXECUTE;
                    // Unknown opcodes retire as a no-op
                    default: next_state = ST_FETCH;
                endcase
            end
            ST_EXECUTE: begin
                if (opcode == OPC_LOAD || opcode == OPC_STORE) begin
                    next_state = ST_MEM;
                end else begin
                    next_state = ST_WRITEBACK;
                end
            end
            ST_MEM: begin
                next_state = (opcode == OPC_LOAD) ? ST_WRITEBACK : ST_FETCH;
            end
            default: begin
                next_state = ST_FETCH;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        // Bus and write enables stay low in reset
        if (!reset) begin
            case (state)
                ST_FETCH: begin
                    ctrl.mem_read  = 1'b1;
                    ctrl.ir_write  = 1'b1;
                    ctrl.alu_src_a = A_PC;
                    ctrl.alu_src_b = B_FOUR;
                    ctrl.pc_write  = 1'b1;
                end
                ST_DECODE: begin
                    // Branch and jump target into the ALU result register
                    ctrl.alu_src_a = A_OLD_PC;
                    ctrl.alu_src_b = B_IMM;
                end
                ST_EXECUTE: begin
                    case (opcode)
                        OPC_OP: begin
                            ctrl.alu_src_a = A_RS1;
                            ctrl.alu_src_b = B_RS2;
                            ctrl.alu_mode  = MODE_FUNCT;
                        end
                        OPC_OP_IMM: begin
                            ctrl.alu_src_a = A_RS1;
                            ctrl.alu_src_b = B_IMM;
                            ctrl.alu_mode  = MODE_FUNCT;
                        end
                        OPC_LUI: begin
                            ctrl.alu_src_a = A_ZERO;
                            ctrl.alu_src_b = B_IMM;
                            ctrl.alu_mode  = MODE_FUNCT;
                        end
                        OPC_JAL: begin
                            // Link value while the PC takes the target
                            ctrl.alu_src_a = A_OLD_PC;
                            ctrl.alu_src_b = B_FOUR;
                            ctrl.pc_write  = 1'b1;
                            ctrl.pc_source = 1'b1;
                        end
                        default: begin
                            ctrl.alu_src_a = A_RS1;
                            ctrl.alu_src_b = B_IMM;
                        end
                    endcase
                end
                ST_BRANCH_DONE: begin
                    ctrl.alu_src_a     = A_RS1;
                    ctrl.alu_src_b     = B_RS2;
                    ctrl.alu_mode      = MODE_BRANCH;
                    ctrl.pc_write_cond = 1'b1;
                    ctrl.branch_ne     = (funct3 == F3_BNE);
                    ctrl.pc_source     = 1'b1;
                end
                ST_MEM: begin
                    ctrl.addr_sel  = 1'b1;
                    ctrl.mem_read  = (opcode == OPC_LOAD);
                    ctrl.mem_write = (opcode == OPC_STORE);
                end
                ST_WRITEBACK: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = (opcode == OPC_LOAD);
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

    a_mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_read && ctrl.mem_write));

    // Instruction register loads only on a fetch, and decode always follows
    a_ir_write_fetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |-> (state == ST_FETCH) ##1 (state == ST_DECODE));

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEM, ST_WRITEBACK, ST_BRANCH_DONE});

endmodule

// File: rtl/core.sv
`timescale 1ns/1ns
`include "core_params.svh"

module core (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] read_data,
    output logic        memory_read,
    output logic        memory_write,
    output logic [31:0] address,
    output logic [31:0] write_data
);
    import isa_pkg::*;
    import core_pkg::*;

    ctrl_t       ctrl;
    instr_u      ir;
    alu_op_e     alu_op;
    logic [31:0] pc;
    logic [31:0] old_pc;
    logic [31:0] memory_reg;
    logic [31:0] a_reg;
    logic [31:0] b_reg;
    logic [31:0] alu_reg;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] immediate;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] pc_next;
    logic [31:0] wb_data;
    logic        alu_zero;
    logic        pc_load;

    assign address      = ctrl.addr_sel ? alu_reg : pc;
    assign memory_read  = ctrl.mem_read;
    assign memory_write = ctrl.mem_write;
    assign write_data   = b_reg;

    always_comb begin
        case (ctrl.alu_src_a)
            A_PC:     alu_a = pc;
            A_RS1:    alu_a = a_reg;
            A_OLD_PC: alu_a = old_pc;
            default:  alu_a = 32'd0;
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_b)
            B_RS2:   alu_b = b_reg;
            B_FOUR:  alu_b = 32'd4;
            B_IMM:   alu_b = immediate;
            default: alu_b = 32'd0;
        endcase
    end

    // BNE inverts the sense of the zero flag
    assign pc_load = ctrl.pc_write | (ctrl.pc_write_cond & (alu_zero ^ ctrl.branch_ne));
    assign pc_next = ctrl.pc_source ? alu_reg : alu_result;
    assign wb_data = ctrl.wb_sel ? memory_reg : alu_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CORE_BOOT_ADDRESS;
            ir <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_next;
            end
            if (ctrl.ir_write) begin
                ir <= read_data;
            end
        end
    end

    // Holding registers between steps
    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            old_pc <= pc;
        end
        if (ctrl.mem_read) begin
            memory_reg <= read_data;
        end
        a_reg   <= rs1_data;
        b_reg   <= rs2_data;
        alu_reg <= alu_result;
    end

    control_fsm control_fsm_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (ir.r.opcode),
        .funct3 (ir.r.funct3),
        .ctrl   (ctrl)
    );

    instr_decode instr_decode_i (
        .instr     (ir),
        .alu_mode  (ctrl.alu_mode),
        .immediate (immediate),
        .alu_op    (alu_op)
    );

    alu alu_i (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    register_file register_file_i (
        .clk          (clk),
        .reset        (reset),
        .write_enable (ctrl.reg_write),
        .read_addr_1  (ir.r.rs1),
        .read_addr_2  (ir.r.rs2),
        .write_addr   (ir.r.rd),
        .write_data   (wb_data),
        .read_data_1  (rs1_data),
        .read_data_2  (rs2_data)
    );

endmodule

// File: rtl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// PC value after reset
`define CORE_BOOT_ADDRESS 32'h0000_0000

// Architectural integer registers
`define CORE_NUM_REGS 32

`endif

// File: rtl/core_pkg.sv
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_WRITEBACK,
        ST_BRANCH_DONE
    } fsm_state_e;

    // Old PC is the address of the instruction in flight
    typedef enum logic [1:0] {
        A_PC,
        A_RS1,
        A_ZERO,
        A_OLD_PC
    } alu_a_sel_e;

    typedef enum logic [1:0] {
        B_RS2,
        B_FOUR,
        B_IMM
    } alu_b_sel_e;

    typedef enum logic [1:0] {
        MODE_ADD,
        MODE_BRANCH,
        MODE_FUNCT
    } alu_mode_e;

    typedef struct packed {
        logic       pc_write;
        logic       pc_write_cond;
        logic       branch_ne;
        logic       addr_sel;      // 1 selects the ALU result register
        logic       mem_read;
        logic       mem_write;
        logic       ir_write;
        logic       wb_sel;        // 1 selects the memory register
        logic       reg_write;
        alu_a_sel_e alu_src_a;
        alu_b_sel_e alu_src_b;
        alu_mode_e  alu_mode;
        logic       pc_source;     // 1 selects the ALU result register
    } ctrl_t;

endpackage

// File: rtl/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
    input  isa_pkg::instr_u     instr,
    input  core_pkg::alu_mode_e alu_mode,
    output logic [31:0]         immediate,
    output core_pkg::alu_op_e   alu_op
);
    import isa_pkg::*;
    import core_pkg::*;

    logic is_alu_opcode;

    assign is_alu_opcode = (instr.r.opcode == OPC_OP) || (instr.r.opcode == OPC_OP_IMM);

    // Immediate layout depends on the format of the opcode
    always_comb begin
        case (instr.r.opcode)
            OPC_OP_IMM, OPC_LOAD: begin
                immediate = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            OPC_STORE: begin
                immediate = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            OPC_BRANCH: begin
                immediate = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                             instr.b.imm_4_1, 1'b0};
            end
            OPC_LUI: begin
                immediate = {instr.u.imm_31_12, 12'd0};
            end
            OPC_JAL: begin
                immediate = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                             instr.j.imm_10_1, 1'b0};
            end
            default: begin
                immediate = 32'd0;
            end
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;
        case (alu_mode)
            MODE_BRANCH: begin
                alu_op = ALU_SUB;
            end
            MODE_FUNCT: begin
                if (is_alu_opcode) begin
                    case (instr.r.funct3)
                        F3_ADD: begin
                            // SUB exists only in the register form
                            if (instr.r.opcode == OPC_OP && instr.r.funct7[5]) begin
                                alu_op = ALU_SUB;
                            end
                        end
                        F3_SLT:  alu_op = ALU_SLT;
                        F3_XOR:  alu_op = ALU_XOR;
                        F3_OR:   alu_op = ALU_OR;
                        F3_AND:  alu_op = ALU_AND;
                        default: alu_op = ALU_ADD;
                    endcase
                end else if (instr.r.opcode == OPC_LUI) begin
                    alu_op = ALU_PASS_B;
                end
            end
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // BEQ shares 000 with ADD
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_BNE = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        funct3_e     funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_format_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_format_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_format_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_format_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
        s_format_t s;
        b_format_t b;
        u_format_t u;
        j_format_t j;
    } instr_u;

endpackage

// File: rtl/register_file.sv
`timescale 1ns/1ns
`include "core_params.svh"

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        write_enable,
    input  logic [4:0]  read_addr_1,
    input  logic [4:0]  read_addr_2,
    input  logic [4:0]  write_addr,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_1,
    output logic [31:0] read_data_2
);

    logic [31:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_enable && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data_1 = regs[read_addr_1];
    assign read_data_2 = regs[read_addr_2];

    // x0 stays zero from reset on because its writes are dropped
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        ((read_addr_1 == 5'd0) |-> (read_data_1 == 32'd0)) and
        ((read_addr_2 == 5'd0) |-> (read_data_2 == 32'd0)));

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_core -f project.f -o tb_core_sim

status=0
output=$(./obj_dir/tb_core_sim) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "simulation exit status: $status"
exit 1

// File: tests/tb_core.sv
`timescale 1ns/1ns
`include "core_params.svh"

module tb_core;
    localparam logic [31:0] BEQ_TAKEN = 32'd148;
    localparam logic [31:0] BEQ_NOT   = 32'd156;
    localparam logic [31:0] BNE_TAKEN = 32'd160;
    localparam logic [31:0] BNE_NOT   = 32'd168;
    localparam logic [31:0] JAL_ADDR  = 32'd172;
    localparam logic [31:0] LOOP_ADDR = 32'd184;

    logic             clk;
    logic             reset;
    logic [31:0]      read_data;
    logic             memory_read;
    logic             memory_write;
    logic [31:0]      address;
    logic [31:0]      write_data;
    logic [7:0][31:0] data_words;
    logic [31:0]      fetch_addr [256];
    int               fetch_cycle [256];
    int               fetch_count = 0;
    int               loop_hits = 0;
    int               cycle = 0;
    logic [31:0]      expected [17];

    core dut_i (
        .clk          (clk),
        .reset        (reset),
        .read_data    (read_data),
        .memory_read  (memory_read),
        .memory_write (memory_write),
        .address      (address),
        .write_data   (write_data)
    );

    tb_memory memory_i (
        .clk          (clk),
        .memory_write (memory_write),
        .address      (address),
        .write_data   (write_data),
        .read_data    (read_data),
        .data_words   (data_words)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic report_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        report_fail();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s: expected %h, actual %h", $time, name, exp, act);
            report_fail();
        end
    endtask

    // Signed compare by sign bits and then magnitude
    function automatic logic [31:0] signed_less(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) begin
            return {31'd0, a[31]};
        end
        return {31'd0, a < b};
    endfunction

    function automatic int find_fetch(input logic [31:0] addr);
        for (int i = 0; i < fetch_count; i++) begin
            if (fetch_addr[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_next_fetch(input string name, input logic [31:0] from,
                                    input logic [31:0] target, input int spacing);
        int idx;
        idx = find_fetch(from);
        assert (idx >= 0 && idx + 1 < fetch_count) else begin
            $display("Instruction at %h was never fetched", from);
            report_fail();
        end
        check_value({name, " next fetch"}, target, fetch_addr[idx + 1]);
        check_value({name, " cycles"}, spacing, fetch_cycle[idx + 1] - fetch_cycle[idx]);
    endtask

    // Program fetches sit below the data region
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset && memory_read && address < 32'h100 && fetch_count < 256) begin
            fetch_addr[fetch_count] <= address;
            fetch_cycle[fetch_count] <= cycle;
            fetch_count <= fetch_count + 1;
            if (address == LOOP_ADDR) begin
                loop_hits <= loop_hits + 1;
            end
        end
    end

    bus_rule: assert property (@(posedge clk)
        !(memory_read && memory_write) && !(reset && (memory_read || memory_write)))
        else begin
            $display("Bus rule broken: read and write together, or bus active in reset");
            report_fail();
        end

    initial begin
        int waited;
        int release_cycle;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        release_cycle = cycle;

        waited = 0;
        while (fetch_count == 0) begin
            @(negedge clk);
            waited++;
            if (waited > 8) timed_out("the first fetch after reset");
        end
        check_value("boot fetch address", `CORE_BOOT_ADDRESS, fetch_addr[0]);
        // First rising edge after release carries the boot fetch
        check_value("boot fetch cycle", release_cycle, fetch_cycle[0]);

        waited = 0;
        while (loop_hits < 2) begin
            @(negedge clk);
            waited++;
            if (waited > 1000) timed_out("the final self-loop");
        end

        check_next_fetch("ADDI", 32'd0, 32'd4, 4);
        check_next_fetch("LW", 32'd8, 32'd12, 5);
        check_next_fetch("taken BEQ", BEQ_TAKEN, BEQ_TAKEN + 8, 3);
        check_next_fetch("skipped BEQ", BEQ_NOT, BEQ_NOT + 4, 3);
        check_next_fetch("taken BNE", BNE_TAKEN, BNE_TAKEN + 8, 3);
        check_next_fetch("skipped BNE", BNE_NOT, BNE_NOT + 4, 3);
        check_next_fetch("JAL", JAL_ADDR, JAL_ADDR + 8, 4);

        expected[0]  = data_words[0] + data_words[1];
        expected[1]  = data_words[0] - data_words[1];
        expected[2]  = data_words[0] & data_words[1];
        expected[3]  = data_words[0] | data_words[1];
        expected[4]  = data_words[0] ^ data_words[1];
        expected[5]  = signed_less(data_words[0], data_words[1]);
        expected[6]  = signed_less(data_words[1], data_words[0]);
        expected[7]  = data_words[2] + 32'hffff_fffb;
        expected[8]  = data_words[2] & 32'h0000_00f0;
        expected[9]  = data_words[3] | 32'h0000_0555;
        expected[10] = data_words[3] ^ 32'hffff_ffff;
        expected[11] = signed_less(data_words[3], 32'd1);
        expected[12] = signed_less(data_words[2], 32'hffff_ffff);
        expected[13] = data_words[0];
        expected[14] = 32'd0;
        expected[15] = 32'habcd_e000;
        expected[16] = JAL_ADDR + 4;

        // Any store from a skipped path shows up as a wrong count or address
        check_value("store_count", 32'd17, memory_i.store_count);
        for (int k = 0; k < 17; k++) begin
            check_value($sformatf("store %0d address", k), 32'h200 + 4 * k,
                        memory_i.stores[k].addr);
            check_value($sformatf("store %0d data", k), expected[k],
                        memory_i.stores[k].data);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: tests/tb_memory.sv
`timescale 1ns/1ns

module tb_memory (
    input  logic             clk,
    input  logic             memory_write,
    input  logic [31:0]      address,
    input  logic [31:0]      write_data,
    output logic [31:0]      read_data,
    output logic [7:0][31:0] data_words
);
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_rec_t;

    logic [31:0] mem [256];
    store_rec_t  stores [32];
    int          store_count = 0;
    integer      seed;
    int          cursor;

    function automatic logic [31:0] op_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, 5'd7, 7'h33};
    endfunction

    function automatic logic [31:0] op_i(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] op_sw(input logic [4:0] rs2, input logic [11:0] imm);
        // Stores always use x2 as the base
        return {imm[11:5], rs2, 5'd2, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] op_b(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] op_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[cursor] = word;
        cursor = cursor + 1;
    endtask

    task automatic emit_store(input logic [31:0] word, input logic [4:0] rs,
                              input logic [11:0] offset);
        emit(word);
        emit(op_sw(rs, offset));
    endtask

    initial begin
        read_data = 32'd0;
        seed = 32'h6bae_ca14;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hc0, i[7:0], ~i[7:0], 8'h5a};
        end
        // Even words positive, odd words negative
        for (int k = 0; k < 8; k++) begin
            data_words[k] = $random(seed);
            data_words[k][31] = k[0];
            mem[64 + k] = data_words[k];
        end
        cursor = 0;
        emit(op_i(7'h13, 3'b000, 5'd1, 5'd0, 12'h100));
        emit(op_i(7'h13, 3'b000, 5'd2, 5'd0, 12'h200));
        emit(op_i(7'h03, 3'b010, 5'd3, 5'd1, 12'h000));
        emit(op_i(7'h03, 3'b010, 5'd4, 5'd1, 12'h004));
        emit(op_i(7'h03, 3'b010, 5'd5, 5'd1, 12'h008));
        emit(op_i(7'h03, 3'b010, 5'd6, 5'd1, 12'h00c));
        emit_store(op_r(7'h00, 3'b000, 5'd3, 5'd4), 5'd7, 12'd0);
        emit_store(op_r(7'h20, 3'b000, 5'd3, 5'd4), 5'd7, 12'd4);
        emit_store(op_r(7'h00, 3'b111, 5'd3, 5'd4), 5'd7, 12'd8);
        emit_store(op_r(7'h00, 3'b110, 5'd3, 5'd4), 5'd7, 12'd12);
        emit_store(op_r(7'h00, 3'b100, 5'd3, 5'd4), 5'd7, 12'd16);
        emit_store(op_r(7'h00, 3'b010, 5'd3, 5'd4), 5'd7, 12'd20);
        emit_store(op_r(7'h00, 3'b010, 5'd4, 5'd3), 5'd7, 12'd24);
        emit_store(op_i(7'h13, 3'b000, 5'd7, 5'd5, 12'hffb), 5'd7, 12'd28);
        emit_store(op_i(7'h13, 3'b111, 5'd7, 5'd5, 12'h0f0), 5'd7, 12'd32);
        emit_store(op_i(7'h13, 3'b110, 5'd7, 5'd6, 12'h555), 5'd7, 12'd36);
        emit_store(op_i(7'h13, 3'b100, 5'd7, 5'd6, 12'hfff), 5'd7, 12'd40);
        emit_store(op_i(7'h13, 3'b010, 5'd7, 5'd6, 12'h001), 5'd7, 12'd44);
        emit_store(op_i(7'h13, 3'b010, 5'd8, 5'd5, 12'hfff), 5'd8, 12'd48);
        emit(op_sw(5'd3, 12'd52));
        emit_store(op_i(7'h13, 3'b000, 5'd0, 5'd3, 12'h007), 5'd0, 12'd56);
        emit_store({20'habcde, 5'd9, 7'h37}, 5'd9, 12'd60);
        // Branches at 148, 156, 160 and 168, JAL at 172, loop at 184
        emit(op_b(3'b000, 5'd3, 5'd3, 13'd8));
        emit(op_sw(5'd3, 12'd80));
        emit(op_b(3'b000, 5'd3, 5'd4, 13'd8));
        emit(op_b(3'b001, 5'd3, 5'd4, 13'd8));
        emit(op_sw(5'd3, 12'd84));
        emit(op_b(3'b001, 5'd3, 5'd3, 13'd8));
        emit(op_jal(5'd10, 21'd8));
        emit(op_sw(5'd3, 12'd88));
        emit(op_sw(5'd10, 12'd64));
        emit(op_jal(5'd0, 21'd0));
    end

    // Address and ctrl settle after the rising edge
    always @(negedge clk) begin
        read_data <= mem[address[9:2]];
    end

    always @(posedge clk) begin
        if (memory_write) begin
            mem[address[9:2]] <= write_data;
            if (store_count < 32) begin
                stores[store_count] <= {address, write_data};
                store_count <= store_count + 1;
            end
        end
    end

endmodule
